// ==== design/wb_pkg.sv ====
// ========================================
// Wishbone classic bus types
// Single access in flight, no burst tags
// Byte select is one bit per data byte
// ========================================

package wb_pkg;

	localparam int WB_ADR_W = 32;            // Byte address
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = WB_DAT_W / 8;  // One select per byte

	// Master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;  // Write data
		logic [WB_SEL_W-1:0] sel;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic                ack;  // One cycle per access
		logic [WB_DAT_W-1:0] dat;  // Read data, valid with ack
	} wb_rsp_t;

endpackage

// ==== design/mm_pkg.sv ====
// ========================================
// Matrix multiply constants and types
// Four signed 8-bit elements per word
// Results are signed 32-bit, no saturation
// ========================================

package mm_pkg;

	localparam int LANES     = 4;               // Elements per word
	localparam int ELEM_W    = 8;
	localparam int WORD_W    = LANES * ELEM_W;
	localparam int ACC_W     = 32;
	localparam int DIM_W     = 16;              // M, N and K
	localparam int REG_ADR_W = 8;               // Decoded low address bits

	// ========================================
	// Register byte offsets
	localparam logic [REG_ADR_W-1:0] REG_CTRL  = 8'h00;  // W bit0 run, R bit0 busy bit1 done
	localparam logic [REG_ADR_W-1:0] REG_SRC_A = 8'h04;
	localparam logic [REG_ADR_W-1:0] REG_SRC_B = 8'h08;  // B stored transposed
	localparam logic [REG_ADR_W-1:0] REG_DEST  = 8'h0C;
	localparam logic [REG_ADR_W-1:0] REG_M     = 8'h10;
	localparam logic [REG_ADR_W-1:0] REG_N     = 8'h14;
	localparam logic [REG_ADR_W-1:0] REG_K     = 8'h18;

	// Job configuration
	typedef struct packed {
		logic [31:0]      src_a;
		logic [31:0]      src_b;
		logic [31:0]      dest;
		logic [DIM_W-1:0] m;
		logic [DIM_W-1:0] n;
		logic [DIM_W-1:0] k;
	} mm_cfg_t;

	// One A word paired with one B word
	typedef struct packed {
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic              first;  // w == 0
		logic              last;   // w == K-1
	} operand_t;

	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// ==== design/sync_fifo.sv ====
// ========================================
// Synchronous FIFO, first-word fall-through
// almost_full at DEPTH - ALMOST_SLACK
// Push when full or pop when empty dropped
// ========================================
`timescale 1ns/1ps

module sync_fifo #(
	parameter int  DEPTH        = 16,
	parameter int  ALMOST_SLACK = 2,
	parameter type T            = logic [31:0]
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic pop,
	input  T     wdata,
	output T     rdata,        // Head, valid while not empty
	output logic empty,
	output logic almost_full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full        = count == CNT_W'(DEPTH);
	assign empty       = count == '0;
	assign almost_full = count >= CNT_W'(DEPTH - ALMOST_SLACK);
	assign do_push     = push && !full;
	assign do_pop      = pop && !empty;
	assign rdata       = mem[rd_ptr];

	// Pointers wrap at DEPTH, any depth allowed
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= wdata;
	end

endmodule

// ==== design/csr_regs.sv ====
// ========================================
// Host register block, Wishbone slave
// Ack one cycle after cyc and stb
// Only low 8 address bits are decoded
// Writes while busy are acked, not applied
// ========================================
`timescale 1ns/1ps

module csr_regs (
	input  logic            clk,
	input  logic            reset,
	input  wb_pkg::wb_req_t host_req,
	output wb_pkg::wb_rsp_t host_rsp,
	input  logic            finished,  // Last result written
	output mm_pkg::mm_cfg_t cfg,
	output logic            start      // One cycle, with run ack
);
	import wb_pkg::*;
	import mm_pkg::*;

	logic                 access;  // New access this cycle
	logic                 wr_en;
	logic [REG_ADR_W-1:0] offset;
	logic                 ack;
	logic                 busy;
	logic                 done;
	logic [WB_DAT_W-1:0]  rd_dat;

	// Ack blocks a second decode of the same access
	assign access = host_req.cyc && host_req.stb && !ack;
	assign wr_en  = access && host_req.we;
	assign offset = host_req.adr[REG_ADR_W-1:0];

	assign host_rsp = '{ack: ack, dat: rd_dat};

	// ========================================
	// Control, status and configuration
	always_ff @(posedge clk) begin
		if (reset) begin
			ack   <= 1'b0;
			start <= 1'b0;
			busy  <= 1'b0;
			done  <= 1'b0;
			cfg   <= '0;
		end else begin
			ack   <= access;
			start <= wr_en && !busy && offset == REG_CTRL && host_req.dat[0];
			if (start) begin
				busy <= 1'b1;
				done <= 1'b0;  // Cleared by the new job
			end else if (finished) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (wr_en && !busy) begin  // Config frozen during a job
				case (offset)
					REG_SRC_A: cfg.src_a <= host_req.dat;
					REG_SRC_B: cfg.src_b <= host_req.dat;
					REG_DEST:  cfg.dest  <= host_req.dat;
					REG_M:     cfg.m     <= host_req.dat[DIM_W-1:0];
					REG_N:     cfg.n     <= host_req.dat[DIM_W-1:0];
					REG_K:     cfg.k     <= host_req.dat[DIM_W-1:0];
					default:   ;         // CTRL handled above
				endcase
			end
		end
	end

	// Read data, returned with ack
	always_ff @(posedge clk) begin
		if (access) begin
			case (offset)
				REG_CTRL:  rd_dat <= WB_DAT_W'({done, busy});
				REG_SRC_A: rd_dat <= cfg.src_a;
				REG_SRC_B: rd_dat <= cfg.src_b;
				REG_DEST:  rd_dat <= cfg.dest;
				REG_M:     rd_dat <= WB_DAT_W'(cfg.m);
				REG_N:     rd_dat <= WB_DAT_W'(cfg.n);
				REG_K:     rd_dat <= WB_DAT_W'(cfg.k);
				default:   rd_dat <= '0;  // Unmapped reads as zero
			endcase
		end
	end

endmodule

// ==== design/operand_fetch.sv ====
// ========================================
// Operand read master
// A row-major M x K, B transposed N x K
// Reads A then B per pair, one access open
// M, N or K of zero is not supported
// ========================================
`timescale 1ns/1ps

module operand_fetch (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  mm_pkg::mm_cfg_t  cfg,
	output wb_pkg::wb_req_t  rd_req,
	input  wb_pkg::wb_rsp_t  rd_rsp,
	output mm_pkg::operand_t op_data,
	output logic             op_push,
	input  logic             op_almost_full  // Back-pressure from the FIFO
);
	import wb_pkg::*;
	import mm_pkg::*;

	localparam logic [WB_ADR_W-1:0] ADR_STEP = WB_ADR_W'(WB_DAT_W / 8);

	typedef enum logic [1:0] {S_IDLE, S_RD_A, S_RD_B, S_HOLD} state_t;

	state_t              state;
	logic [DIM_W-1:0]    i_cnt;   // Row of A
	logic [DIM_W-1:0]    j_cnt;   // Row of transposed B
	logic [DIM_W-1:0]    w_cnt;   // Word within the row
	logic [WB_ADR_W-1:0] a_row;   // Base of current A row
	logic [WB_ADR_W-1:0] a_addr;
	logic [WB_ADR_W-1:0] b_addr;
	logic [WB_DAT_W-1:0] a_word;  // Held until B returns
	logic                w_end;
	logic                j_end;
	logic                i_end;
	logic                step;    // B ack, pair complete

	assign w_end = w_cnt == cfg.k - 1'b1;
	assign j_end = j_cnt == cfg.n - 1'b1;
	assign i_end = i_cnt == cfg.m - 1'b1;
	assign step  = state == S_RD_B && rd_rsp.ack;

	// Read only, address follows the state
	always_comb begin
		rd_req     = '0;
		rd_req.cyc = state == S_RD_A || state == S_RD_B;
		rd_req.stb = rd_req.cyc;
		rd_req.adr = (state == S_RD_B) ? b_addr : a_addr;
		rd_req.sel = '1;
	end

	// ========================================
	// Fetch FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_IDLE;
			op_push <= 1'b0;
		end else begin
			op_push <= step;
			case (state)
				S_IDLE: if (start) state <= S_RD_A;
				S_RD_A: if (rd_rsp.ack) state <= S_RD_B;
				S_RD_B: begin
					if (rd_rsp.ack) begin
						if (w_end && j_end && i_end)
							state <= S_IDLE;  // Last pair of the job
						else if (op_almost_full)
							state <= S_HOLD;
						else
							state <= S_RD_A;
					end
				end
				S_HOLD: if (!op_almost_full) state <= S_RD_A;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Loop counters, w innermost
	always_ff @(posedge clk) begin
		if (reset || start) begin
			i_cnt <= '0;
			j_cnt <= '0;
			w_cnt <= '0;
		end else if (step) begin
			w_cnt <= w_end ? '0 : w_cnt + 1'b1;
			if (w_end) begin
				j_cnt <= j_end ? '0 : j_cnt + 1'b1;
				if (j_end) i_cnt <= i_cnt + 1'b1;
			end
		end
	end

	// Running addresses, no multipliers
	always_ff @(posedge clk) begin
		if (start) begin
			a_row  <= cfg.src_a;
			a_addr <= cfg.src_a;
			b_addr <= cfg.src_b;
		end else if (step) begin
			if (!w_end) begin
				a_addr <= a_addr + ADR_STEP;
				b_addr <= b_addr + ADR_STEP;
			end else if (!j_end) begin
				a_addr <= a_row;               // Same A row, next B row
				b_addr <= b_addr + ADR_STEP;   // B rows are contiguous
			end else begin
				a_row  <= a_addr + ADR_STEP;   // Next A row, K words on
				a_addr <= a_addr + ADR_STEP;
				b_addr <= cfg.src_b;           // Rewind B
			end
		end
	end

	// Operand capture
	always_ff @(posedge clk) begin
		if (state == S_RD_A && rd_rsp.ack) a_word <= rd_rsp.dat;
		if (step) op_data <= '{a: a_word, b: rd_rsp.dat, first: w_cnt == '0, last: w_end};
	end

endmodule

// ==== design/dot_product.sv ====
// ========================================
// Dot-product pipeline, 3 stages
// Multiply, adder tree, accumulate over K
// Pops only with room for 3 in flight
// Sums wrap at 32 bits
// ========================================
`timescale 1ns/1ps

module dot_product (
	input  logic             clk,
	input  logic             reset,
	input  mm_pkg::operand_t op_data,
	input  logic             op_empty,
	output logic             op_pop,
	output mm_pkg::acc_t     res_data,
	output logic             res_push,
	input  logic             res_almost_full  // Slack of 3 expected
);
	import mm_pkg::*;

	localparam int PROD_W = 2 * ELEM_W;
	localparam int PAIRS  = LANES / 2;

	logic                     s1_vld;
	logic                     s1_first;
	logic                     s1_last;
	logic signed [PROD_W-1:0] s1_prod [LANES];  // Lane products
	acc_t                     pair_sum [PAIRS];
	acc_t                     tree_sum;
	logic                     s2_vld;
	logic                     s2_first;
	logic                     s2_last;
	acc_t                     s2_sum;
	logic                     acc_vld;
	logic                     acc_last;
	acc_t                     acc;

	assign op_pop   = !op_empty && !res_almost_full;
	assign res_push = acc_vld && acc_last;  // Row and column done
	assign res_data = acc;

	// Valid bits through the stages
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_vld  <= 1'b0;
			s2_vld  <= 1'b0;
			acc_vld <= 1'b0;
		end else begin
			s1_vld  <= op_pop;
			s2_vld  <= s1_vld;
			acc_vld <= s2_vld;
		end
	end

	// ========================================
	// Stage 1, signed 8x8 per lane
	always_ff @(posedge clk) begin
		s1_first <= op_data.first;
		s1_last  <= op_data.last;
		for (int l = 0; l < LANES; l++) begin
			s1_prod[l] <= $signed(op_data.a[l*ELEM_W +: ELEM_W])
				* $signed(op_data.b[l*ELEM_W +: ELEM_W]);
		end
	end

	// Stage 2, pairs then total
	always_comb begin
		tree_sum = '0;
		for (int p = 0; p < PAIRS; p++) begin
			pair_sum[p] = acc_t'(s1_prod[2*p]) + acc_t'(s1_prod[2*p+1]);  // Sign extended
			tree_sum    = tree_sum + pair_sum[p];
		end
	end

	always_ff @(posedge clk) begin
		s2_first <= s1_first;
		s2_last  <= s1_last;
		s2_sum   <= tree_sum;
	end

	// Stage 3, load on first word of a row
	always_ff @(posedge clk) begin
		acc_last <= s2_last;
		if (s2_vld) acc <= s2_first ? s2_sum : acc + s2_sum;
	end

endmodule

// ==== design/result_writer.sv ====
// ========================================
// Result write master
// Row-major C at dest, one word per result
// Data comes straight from the FIFO head
// ========================================
`timescale 1ns/1ps

module result_writer (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  mm_pkg::mm_cfg_t cfg,
	input  mm_pkg::acc_t    res_data,
	input  logic            res_empty,
	output logic            res_pop,
	output wb_pkg::wb_req_t wr_req,
	input  wb_pkg::wb_rsp_t wr_rsp,
	output logic            finished   // Ack of write M*N
);
	import wb_pkg::*;
	import mm_pkg::*;

	localparam logic [WB_ADR_W-1:0] ADR_STEP = WB_ADR_W'(WB_DAT_W / 8);

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_WRITE} state_t;

	state_t               state;
	logic [WB_ADR_W-1:0]  addr;
	logic [2*DIM_W-1:0]   wr_count;  // Writes acked so far
	logic [2*DIM_W-1:0]   total;     // M*N
	logic                 last_write;

	assign last_write = wr_count == total - 1'b1;
	assign res_pop    = state == S_WRITE && wr_rsp.ack;  // Head consumed on ack
	assign finished   = res_pop && last_write;

	always_comb begin
		wr_req     = '0;
		wr_req.cyc = state == S_WRITE;
		wr_req.stb = wr_req.cyc;
		wr_req.we  = 1'b1;
		wr_req.adr = addr;
		wr_req.dat = res_data;  // Stable until pop
		wr_req.sel = '1;
	end

	// ========================================
	// Write FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= S_IDLE;
			wr_count <= '0;
		end else begin
			if (start) wr_count <= '0;
			else if (res_pop) wr_count <= wr_count + 1'b1;
			case (state)
				S_IDLE:  if (start) state <= S_WAIT;
				S_WAIT:  if (!res_empty) state <= S_WRITE;
				S_WRITE: if (wr_rsp.ack) state <= last_write ? S_IDLE : S_WAIT;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Address and job size
	always_ff @(posedge clk) begin
		if (start) begin
			addr  <= cfg.dest;
			total <= cfg.m * cfg.n;
		end else if (res_pop) begin
			addr <= addr + ADR_STEP;
		end
	end

endmodule

// ==== design/matmul_top.sv ====
// ========================================
// Matrix multiply accelerator top
// Host slave port, separate read and write masters
// FIFO depths set here and passed down
// ========================================
`timescale 1ns/1ps

module matmul_top #(
	parameter int OPERAND_DEPTH = 16,
	parameter int RESULT_DEPTH  = 8
) (
	input  logic            clk,
	input  logic            reset,
	input  wb_pkg::wb_req_t host_req,
	output wb_pkg::wb_rsp_t host_rsp,
	output wb_pkg::wb_req_t rd_req,
	input  wb_pkg::wb_rsp_t rd_rsp,
	output wb_pkg::wb_req_t wr_req,
	input  wb_pkg::wb_rsp_t wr_rsp
);
	import mm_pkg::*;

	localparam int OPERAND_SLACK = 2;  // Covers the registered push
	localparam int RESULT_SLACK  = 3;  // Pipeline items in flight

	mm_cfg_t  cfg;
	logic     start;
	logic     finished;
	operand_t op_wdata;
	operand_t op_rdata;
	logic     op_push;
	logic     op_pop;
	logic     op_empty;
	logic     op_almost_full;
	acc_t     res_wdata;
	acc_t     res_rdata;
	logic     res_push;
	logic     res_pop;
	logic     res_empty;
	logic     res_almost_full;

	csr_regs u_csr (.clk, .reset, .host_req, .host_rsp, .finished, .cfg, .start);

	operand_fetch u_fetch (
		.clk, .reset, .start, .cfg, .rd_req, .rd_rsp,
		.op_data (op_wdata),
		.op_push, .op_almost_full
	);

	sync_fifo #(.DEPTH(OPERAND_DEPTH), .ALMOST_SLACK(OPERAND_SLACK), .T(operand_t)) u_op_fifo (
		.clk, .reset,
		.push (op_push), .pop (op_pop), .wdata (op_wdata), .rdata (op_rdata),
		.empty (op_empty), .almost_full (op_almost_full)
	);

	dot_product u_dot (
		.clk, .reset,
		.op_data (op_rdata), .op_empty, .op_pop,
		.res_data (res_wdata), .res_push, .res_almost_full
	);

	sync_fifo #(.DEPTH(RESULT_DEPTH), .ALMOST_SLACK(RESULT_SLACK), .T(acc_t)) u_res_fifo (
		.clk, .reset,
		.push (res_push), .pop (res_pop), .wdata (res_wdata), .rdata (res_rdata),
		.empty (res_empty), .almost_full (res_almost_full)
	);

	result_writer u_writer (
		.clk, .reset, .start, .cfg,
		.res_data (res_rdata), .res_empty, .res_pop,
		.wr_req, .wr_rsp, .finished
	);

endmodule

// ==== tests/wb_mem_model.sv ====
// ========================================
// Word memory, Wishbone read and write port
// Byte address bits above 1:0 pick a word
// Ack after a random 0 to 3 wait states
// sel is ignored and whole words are written
// ========================================
`timescale 1ns/1ps

module wb_mem_model #(
	parameter int WORDS = 1024,
	parameter int SEED  = 1
) (
	input  logic            clk,
	input  logic            reset,
	input  wb_pkg::wb_req_t rd_req,
	output wb_pkg::wb_rsp_t rd_rsp,
	input  wb_pkg::wb_req_t wr_req,
	output wb_pkg::wb_rsp_t wr_rsp,
	output logic            wr_dup   // Word was already written, valid with ack
);
	import wb_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	logic [WB_DAT_W-1:0] mem [WORDS];
	logic                written [WORDS];  // Write log since last clear
	logic [IDX_W-1:0]    rd_idx;
	logic [IDX_W-1:0]    wr_idx;
	logic                rd_pend;
	logic                wr_pend;
	logic [1:0]          rd_wait;          // Wait states still to go
	logic [1:0]          wr_wait;
	int                  seed;

	assign rd_idx = rd_req.adr[IDX_W+1:2];
	assign wr_idx = wr_req.adr[IDX_W+1:2];

	initial begin
		seed   = SEED;
		rd_rsp = '0;  // Quiet responses before the first edge
		wr_rsp = '0;
		wr_dup = 1'b0;
		for (int i = 0; i < WORDS; i++) begin
			mem[i]     = 32'hc0de_0000 ^ i;  // Fill follows the whole index
			written[i] = 1'b0;
		end
	end

	// ========================================
	// Both ports with one draw order per cycle
	always @(posedge clk) begin : ports
		logic [31:0] draw;
		logic [1:0]  left;
		if (reset) begin
			rd_rsp  <= '0;
			wr_rsp  <= '0;
			wr_dup  <= 1'b0;
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
		end else begin
			rd_rsp.ack <= 1'b0;
			wr_rsp.ack <= 1'b0;
			wr_dup     <= 1'b0;
			if (rd_req.cyc && rd_req.stb && !rd_rsp.ack) begin
				draw = $random(seed);
				left = rd_pend ? rd_wait : draw[1:0];  // New access draws its delay
				if (left == 2'd0) begin
					rd_pend    <= 1'b0;
					rd_rsp.ack <= 1'b1;
					rd_rsp.dat <= mem[rd_idx];
				end else begin
					rd_pend <= 1'b1;
					rd_wait <= left - 1'b1;
				end
			end
			if (wr_req.cyc && wr_req.stb && wr_req.we && !wr_rsp.ack) begin
				draw = $random(seed);
				left = wr_pend ? wr_wait : draw[1:0];
				if (left == 2'd0) begin
					wr_pend         <= 1'b0;
					wr_rsp.ack      <= 1'b1;
					mem[wr_idx]     <= wr_req.dat;
					written[wr_idx] <= 1'b1;
					wr_dup          <= written[wr_idx];  // Repeat of a logged address
				end else begin
					wr_pend <= 1'b1;
					wr_wait <= left - 1'b1;
				end
			end
		end
	end

	// Backdoor for loading and checking
	task automatic poke(input int idx, input logic [31:0] data);
		mem[idx] = data;
	endtask

	function automatic logic [31:0] peek(input int idx);
		return mem[idx];
	endfunction

	task automatic clear_log();
		for (int i = 0; i < WORDS; i++) written[i] = 1'b0;
	endtask

endmodule

// ==== tests/tb_matmul_top.sv ====
// ========================================
// Testbench for the matrix multiply top
// A at word 0, B at word 256, C at word 512
// Jobs must fit the 1024-word memory
// Stops at the first failed check
// ========================================
`timescale 1ns/1ps

module tb_matmul_top;
	import wb_pkg::*;
	import mm_pkg::*;

	localparam int          TIMEOUT_CYCLES = 20000;  // About 5x the test length
	localparam logic [31:0] SEED  = 32'h14c2_07f8;
	localparam logic [31:0] SRC_A = 32'h0000_0000;
	localparam logic [31:0] SRC_B = 32'h0000_0400;
	localparam logic [31:0] DEST  = 32'h0000_0800;

	logic        clk;
	logic        reset;
	wb_req_t     host_req;
	wb_rsp_t     host_rsp;
	wb_req_t     rd_req;
	wb_rsp_t     rd_rsp;
	wb_req_t     wr_req;
	wb_rsp_t     wr_rsp;
	logic        wr_dup;
	int          seed;
	int          cycle_count = 0;
	int          fail_count;
	string       test_name;
	logic        chk_en;   // Value check strobe
	logic [31:0] chk_exp;
	logic [31:0] chk_act;
	logic [31:0] job_lo;   // Legal result window
	logic [31:0] job_hi;
	logic [31:0] rd_val;
	logic [31:0] a_words [$];
	logic [31:0] b_words [$];

	// Small operand FIFO to exercise back-pressure
	matmul_top #(.OPERAND_DEPTH(4), .RESULT_DEPTH(8)) uut (
		.clk, .reset, .host_req, .host_rsp, .rd_req, .rd_rsp, .wr_req, .wr_rsp
	);

	wb_mem_model #(.WORDS(1024), .SEED(SEED)) u_mem (
		.clk, .reset, .rd_req, .rd_rsp, .wr_req, .wr_rsp, .wr_dup
	);

	always #4 clk = ~clk;

	task automatic stop_with_failure(input string what);
		fail_count++;
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_with_failure($sformatf("timeout after %0d cycles, no done", cycle_count));
	end

	// ========================================
	// Checks
	a_value: assert property (@(posedge clk) chk_en |-> chk_exp == chk_act)
		else stop_with_failure($sformatf("error %s: expected %08h, actual %08h",
			test_name, chk_exp, chk_act));
	a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !(rd_req.cyc || rd_req.stb
		|| wr_req.cyc || wr_req.stb || host_rsp.ack || rd_rsp.ack || wr_rsp.ack))
		else stop_with_failure("bus signals active right after reset");
	a_idle_masters: assert property (@(posedge clk) disable iff (reset)
		!uut.u_csr.busy |-> !rd_req.cyc && !wr_req.cyc)
		else stop_with_failure("master port cycle while not busy");
	a_rd_hold: assert property (@(posedge clk) disable iff (reset)
		rd_req.stb && !rd_rsp.ack |=> rd_req.stb && $stable(rd_req.adr))
		else stop_with_failure("read request dropped or moved before ack");
	a_wr_hold: assert property (@(posedge clk) disable iff (reset)
		wr_req.stb && !wr_rsp.ack |=> wr_req.stb && $stable(wr_req.adr) && $stable(wr_req.dat))
		else stop_with_failure("write request dropped or changed before ack");
	a_rd_only: assert property (@(posedge clk) disable iff (reset)
		rd_req.cyc |-> !rd_req.we)
		else stop_with_failure("read port raised write enable");
	a_wr_full: assert property (@(posedge clk) disable iff (reset)
		wr_req.cyc |-> wr_req.we && wr_req.sel == '1)
		else stop_with_failure("write port access without write enable or full byte select");
	a_host_ack_time: assert property (@(posedge clk) disable iff (reset)
		host_req.cyc && host_req.stb && !host_rsp.ack |=> host_rsp.ack)
		else stop_with_failure("register ack not one cycle after the request");
	a_host_ack: assert property (@(posedge clk) disable iff (reset)
		host_rsp.ack |=> !host_rsp.ack)
		else stop_with_failure("register ack held for two cycles");
	a_wr_window: assert property (@(posedge clk) disable iff (reset) wr_req.stb |->
		wr_req.adr >= job_lo && wr_req.adr < job_hi && wr_req.adr[1:0] == 2'b00)
		else stop_with_failure("result write outside the destination area");
	a_wr_unique: assert property (@(posedge clk) disable iff (reset) wr_rsp.ack |-> !wr_dup)
		else stop_with_failure("result address written twice in one job");

	// ========================================
	// Host and check tasks start 1 ns after an edge
	task automatic host_access(input logic we, input logic [7:0] offset,
		input logic [31:0] data, output logic [31:0] rdata);
		host_req     = '0;
		host_req.cyc = 1'b1;
		host_req.stb = 1'b1;
		host_req.we  = we;
		host_req.adr = 32'(offset);
		host_req.dat = data;
		host_req.sel = '1;
		do @(negedge clk); while (!host_rsp.ack);  // Mid-cycle sample
		rdata = host_rsp.dat;
		@(posedge clk);
		#1;
		host_req = '0;
	endtask

	task automatic host_write(input logic [7:0] offset, input logic [31:0] data);
		logic [31:0] unused;
		host_access(1'b1, offset, data, unused);
	endtask

	task automatic host_read(input logic [7:0] offset, output logic [31:0] data);
		host_access(1'b0, offset, 32'h0, data);
	endtask

	task automatic expect_value(input logic [31:0] expected, input logic [31:0] actual);
		chk_exp = expected;
		chk_act = actual;
		chk_en  = 1'b1;
		@(posedge clk);  // Assertion samples here
		#1;
		chk_en = 1'b0;
	endtask

	task automatic write_readback(input logic [7:0] offset, input logic [31:0] data,
		input logic [31:0] expected);
		host_write(offset, data);
		host_read(offset, rd_val);
		expect_value(expected, rd_val);
	endtask

	task automatic load_job(input int m, input int n, input int k);
		a_words.delete();
		b_words.delete();
		for (int x = 0; x < m * k; x++) begin
			a_words.push_back($random(seed));
			u_mem.poke(SRC_A / 4 + x, a_words[x]);
		end
		for (int x = 0; x < n * k; x++) begin
			b_words.push_back($random(seed));  // B rows are columns of B
			u_mem.poke(SRC_B / 4 + x, b_words[x]);
		end
	endtask

	task automatic start_job(input int m, input int n, input int k);
		host_write(REG_SRC_A, SRC_A);
		host_write(REG_SRC_B, SRC_B);
		host_write(REG_DEST, DEST);
		host_write(REG_M, m);
		host_write(REG_N, n);
		host_write(REG_K, k);
		u_mem.clear_log();
		job_lo = DEST;
		job_hi = DEST + 4 * m * n;
		host_write(REG_CTRL, 32'h1);
	endtask

	task automatic wait_done();
		logic [31:0] status;
		status = '0;
		while (!status[1]) host_read(REG_CTRL, status);  // Watchdog bounds this
	endtask

	// Reference C from four signed bytes per word summed into 32 bits
	task automatic check_results(input int m, input int n, input int k);
		int          acc;
		logic [31:0] aw;
		logic [31:0] bw;
		for (int i = 0; i < m; i++) begin
			for (int j = 0; j < n; j++) begin
				acc = 0;
				for (int w = 0; w < k; w++) begin
					aw = a_words[i * k + w];
					bw = b_words[j * k + w];
					for (int l = 0; l < 4; l++)
						acc += int'($signed(aw[l*8 +: 8])) * int'($signed(bw[l*8 +: 8]));
				end
				expect_value(acc, u_mem.peek(DEST / 4 + i * n + j));
			end
		end
	endtask

	// ========================================
	// Test sequence
	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		host_req   = '0;
		seed       = SEED;
		fail_count = 0;
		chk_en     = 1'b0;
		chk_exp    = '0;
		chk_act    = '0;
		job_lo     = DEST;
		job_hi     = DEST;
		test_name  = "reset";
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		test_name = "reset_ctrl";
		host_read(REG_CTRL, rd_val);
		expect_value(32'h0, rd_val);

		test_name = "cfg_readback";                      // Sizes keep 16 bits
		write_readback(REG_SRC_A, 32'h1357_9bdf, 32'h1357_9bdf);
		write_readback(REG_SRC_B, 32'h2468_ace0, 32'h2468_ace0);
		write_readback(REG_DEST, 32'hfedc_ba98, 32'hfedc_ba98);
		write_readback(REG_M, 32'h0001_0007, 32'h0000_0007);
		write_readback(REG_N, 32'h00ab_0005, 32'h0000_0005);
		write_readback(REG_K, 32'h0000_1234, 32'h0000_1234);

		test_name = "small_job";
		load_job(2, 3, 2);
		start_job(2, 3, 2);
		host_read(REG_CTRL, rd_val);
		expect_value(32'h1, rd_val);   // Busy but not done
		wait_done();
		host_read(REG_CTRL, rd_val);
		expect_value(32'h2, rd_val);   // Done with busy clear
		check_results(2, 3, 2);

		test_name = "large_job";
		load_job(4, 4, 8);
		start_job(4, 4, 8);
		host_write(REG_M, 32'd9);      // All ignored while busy
		host_write(REG_N, 32'd2);
		host_write(REG_K, 32'd1);
		host_write(REG_DEST, 32'h0000_0100);
		host_read(REG_M, rd_val);
		expect_value(32'd4, rd_val);
		wait_done();
		check_results(4, 4, 8);

		test_name = "rerun_job";
		load_job(3, 5, 3);
		start_job(3, 5, 3);
		host_read(REG_CTRL, rd_val);
		expect_value(32'h1, rd_val);   // Done cleared by the new run
		wait_done();
		check_results(3, 5, 3);

		if (fail_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_with_failure("checks failed");
		end
	end

endmodule

// ==== flist.f ====
design/wb_pkg.sv
design/mm_pkg.sv
design/sync_fifo.sv
design/csr_regs.sv
design/operand_fetch.sv
design/dot_product.sv
design/result_writer.sv
design/matmul_top.sv
tests/wb_mem_model.sv
tests/tb_matmul_top.sv

// ==== Bender.yml ====
package:
  name: matmul_accel

sources:
  - files:
      - design/wb_pkg.sv
      - design/mm_pkg.sv
      - design/sync_fifo.sv
      - design/csr_regs.sv
      - design/operand_fetch.sv
      - design/dot_product.sv
      - design/result_writer.sv
      - design/matmul_top.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/tb_matmul_top.sv
